// File: tests/frame_checker_golden.txt
# b0..b7 data bytes and b8 check byte (hex), abort bit count (decimal, 0 = full frame),
# expected fold (hex), expected kind (0 = good, 1 = bad)
01 02 03 04 05 06 07 08 db 0 24 0
00 00 00 00 00 00 00 00 ff 0 00 0
ff ff ff ff ff ff ff ff 00 0 ff 0
ff ff ff ff ff ff ff ff 01 0 ff 1
12 34 56 78 9a bc de f0 c3 36 00 0
12 34 56 78 9a bc de f0 c3 0 3c 0
ff ff ff ff ff ff ff 06 fa 0 05 0
ff ff ff ff ff ff ff 06 00 0 05 1
a5 5a c3 3c 81 7e 00 ff 00 71 00 0
a5 5a c3 3c 81 7e 00 ff ff 0 ff 1
ff ff ff ff ff ff 05 00 fb 0 04 0
80 80 80 80 80 80 80 80 fb 1 00 0
80 80 80 80 80 80 80 80 fb 0 04 0
10 20 30 40 50 60 70 80 bd 8 00 0
10 20 30 40 50 60 70 80 bd 0 42 0
12 34 56 78 9a bc de f0 c4 0 3c 1
de ad be ef ca fe ba be 81 64 00 0
de ad be ef ca fe ba be 81 0 7e 0
de ad be ef ca fe ba be 80 0 7e 1
01 02 03 04 05 06 07 08 00 9 00 0
01 02 03 04 05 06 07 08 00 0 24 1

// File: frame_checker_top.f
design/checksum_pkg.sv
design/frame_ctrl_fsm.sv
design/bit_byte_counter.sv
design/serial_deserializer.sv
design/checksum_accumulator.sv
design/frame_checker_top.sv
tests/frame_checker_tb.sv

// File: Bender.yml
package:
  name: frame_checker

sources:
  - design/checksum_pkg.sv
  - design/frame_ctrl_fsm.sv
  - design/bit_byte_counter.sv
  - design/serial_deserializer.sv
  - design/checksum_accumulator.sv
  - design/frame_checker_top.sv
  - target: test
    files:
      - tests/frame_checker_tb.sv

// File: tests/frame_checker_tb.sv
`timescale 1ns/1ps

module frame_checker_tb
    import checksum_pkg::*;
();

    localparam int FRAME_BITS = 72;
    localparam int WAIT_LIMIT = 200;

    logic          clk;
    logic          arst_n;
    logic          en;
    logic          data;
    logic          result_req;
    logic          result_ack;
    frame_result_e result_kind;
    logic [7:0]    result_sum;

    logic [31:0]   lfsr_q;
    int            extra_left;
    int            checks_done;
    int            full_frames;

    frame_checker_top u_frame_checker_top (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .en_i          (en),
        .data_i        (data),
        .result_req_o  (result_req),
        .result_ack_i  (result_ack),
        .result_kind_o (result_kind),
        .result_sum_o  (result_sum)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    // ==============================
    // reporting and compares
    // ==============================

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_kind(input string name, input frame_result_e exp_kind,
                              input frame_result_e act_kind);
        checks_done++;
        if (act_kind !== exp_kind)
        begin
            stop_with_error($sformatf("FAILED %s: expected %s actual %s",
                                      name, exp_kind.name(), act_kind.name()));
        end
    endtask

    task automatic check_sum(input string name, input logic [7:0] exp_sum,
                             input logic [7:0] act_sum);
        checks_done++;
        if (act_sum !== exp_sum)
        begin
            stop_with_error($sformatf("FAILED %s: expected %02h actual %02h",
                                      name, exp_sum, act_sum));
        end
    endtask

    task automatic check_cycles(input string name, input int exp_cycles, input int act_cycles);
        checks_done++;
        if (act_cycles != exp_cycles)
        begin
            stop_with_error($sformatf("FAILED %s: expected %0d actual %0d",
                                      name, exp_cycles, act_cycles));
        end
    endtask

    // ==============================
    // random source and reference model
    // ==============================

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = (value << 1) | int'(lfsr_q[0]);
        end
    endtask

    // sum of the eight data bytes with the high byte folded onto the low byte.
    function automatic logic [7:0] fold_of(input logic [71:0] bits);
        logic [15:0] total;
        total = 16'd0;
        for (int k = 0; k < 8; k++)
        begin
            total = total + 16'(bits[8*k +: 8]);
        end
        return total[15:8] + total[7:0];
    endfunction

    function automatic frame_result_e kind_of(input logic [71:0] bits);
        logic [7:0] total;
        total = fold_of(bits) + bits[71:64];
        if (total == 8'hFF)
        begin
            return RES_GOOD;
        end
        else
        begin
            return RES_BAD;
        end
    endfunction

    // ==============================
    // serial side
    // ==============================

    // trailing bits with en high go out here while extra_left runs down.
    task automatic idle_cycle();
        int bit_val;
        @(negedge clk);
        if (extra_left > 0)
        begin
            take_bits(1, bit_val);
            en         = 1'b1;
            data       = bit_val[0];
            extra_left = extra_left - 1;
        end
        else
        begin
            en   = 1'b0;
            data = 1'b0;
        end
    endtask

    task automatic idle_gap();
        int gap;
        take_bits(3, gap);
        repeat (2 + gap)
        begin
            idle_cycle();
        end
    endtask

    task automatic send_bits(input logic [71:0] bits, input int count);
        for (int i = 0; i < count; i++)
        begin
            @(negedge clk);
            en   = 1'b1;
            data = bits[i];
        end
    endtask

    // ==============================
    // result side
    // ==============================

    task automatic wait_for_request(input string name, output int cycles);
        cycles = 0;
        while (!result_req)
        begin
            if (cycles == WAIT_LIMIT)
            begin
                stop_with_error({"timeout waiting for result_req_o to rise in ", name});
            end
            idle_cycle();
            cycles++;
        end
    endtask

    task automatic check_no_request(input string name);
        for (int i = 0; i < WAIT_LIMIT; i++)
        begin
            idle_cycle();
            if (result_req)
            begin
                stop_with_error({"result_req_o rose after the aborted ", name});
            end
        end
    endtask

    task automatic handshake(input string name, input logic [7:0] exp_fold,
                             input frame_result_e exp_kind);
        int delay;
        int cycles;
        take_bits(4, delay);
        check_kind({name, " kind"}, exp_kind, result_kind);
        check_sum({name, " fold"}, exp_fold, result_sum);
        for (int i = 0; i < delay; i++)
        begin
            idle_cycle();
            if (!result_req)
            begin
                stop_with_error({"result_req_o fell before result_ack_i in ", name});
            end
            check_kind({name, " kind held"}, exp_kind, result_kind);
            check_sum({name, " fold held"}, exp_fold, result_sum);
        end
        idle_cycle();
        result_ack = 1'b1;
        cycles     = 0;
        while (result_req)
        begin
            if (cycles == WAIT_LIMIT)
            begin
                stop_with_error({"timeout waiting for result_req_o to fall in ", name});
            end
            idle_cycle();
            cycles++;
        end
        check_cycles({name, " ack to release"}, 1, cycles);
        repeat (2)
        begin
            idle_cycle();
            if (result_req)
            begin
                stop_with_error({"new request while result_ack_i was high in ", name});
            end
        end
        idle_cycle();
        result_ack = 1'b0;
        extra_left = 0;
    endtask

    task automatic run_full_frame(input string name, input logic [71:0] bits,
                                  input logic [7:0] exp_fold, input frame_result_e exp_kind,
                                  input logic with_extra);
        int extra;
        int cycles;
        send_bits(bits, FRAME_BITS);
        if (with_extra)
        begin
            take_bits(3, extra);
            extra_left = extra + 1;
        end
        wait_for_request(name, cycles);
        // first negedge follows the edge that took bit 72.
        check_cycles({name, " request latency"}, 2, cycles - 1);
        handshake(name, exp_fold, exp_kind);
    endtask

    task automatic reset_now(input string name);
        arst_n = 1'b0;
        #1;
        if (result_req)
        begin
            stop_with_error({"result_req_o stayed high in ", name});
        end
        check_sum({name, " fold after reset"}, 8'd0, result_sum);
        check_kind({name, " kind after reset"}, RES_GOOD, result_kind);
        @(negedge clk);
        en         = 1'b0;
        data       = 1'b0;
        result_ack = 1'b0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial
    begin
        int            fd;
        int            status;
        int            fields;
        int            abort_n;
        int            kind_val;
        int            frame_idx;
        string         line;
        string         name;
        logic [7:0]    rd [0:8];
        logic [7:0]    exp_fold;
        logic [71:0]   bits;
        logic [71:0]   last_bits;
        logic [7:0]    last_fold;
        frame_result_e exp_kind;
        frame_result_e last_kind;

        lfsr_q      = 32'hcb09;
        extra_left  = 0;
        checks_done = 0;
        full_frames = 0;
        frame_idx   = 0;
        last_bits   = '0;
        last_fold   = '0;
        last_kind   = RES_GOOD;
        arst_n      = 1'b0;
        en          = 1'b0;
        data        = 1'b0;
        result_ack  = 1'b0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        fd = $fopen("tests/frame_checker_golden.txt", "r");
        if (fd == 0)
        begin
            stop_with_error("could not open tests/frame_checker_golden.txt");
        end
        while (!$feof(fd))
        begin
            status = $fgets(line, fd);
            if (status > 0 && line.len() > 1 && line.getc(0) != "#")
            begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %d %h %d",
                                 rd[0], rd[1], rd[2], rd[3], rd[4], rd[5], rd[6], rd[7],
                                 rd[8], abort_n, exp_fold, kind_val);
                if (fields != 12)
                begin
                    stop_with_error({"malformed line in the golden file: ", line});
                end
                for (int k = 0; k < 9; k++)
                begin
                    bits[8*k +: 8] = rd[k];
                end
                exp_kind = (kind_val == 1) ? RES_BAD : RES_GOOD;
                frame_idx++;
                name = $sformatf("frame %0d", frame_idx);
                idle_gap();
                if (abort_n == 0)
                begin
                    if (fold_of(bits) != exp_fold || kind_of(bits) != exp_kind)
                    begin
                        stop_with_error({name, " in the golden file breaks the checksum rule"});
                    end
                    run_full_frame(name, bits, exp_fold, exp_kind, (full_frames % 3) == 2);
                    full_frames++;
                    last_bits = bits;
                    last_fold = exp_fold;
                    last_kind = exp_kind;
                end
                else
                begin
                    send_bits(bits, abort_n);
                    check_no_request(name);
                end
            end
        end
        $fclose(fd);

        // reset while a result waits for its ack.
        idle_gap();
        send_bits(last_bits, FRAME_BITS);
        wait_for_request("reset in report", status);
        reset_now("reset in report");

        // reset halfway through a frame.
        idle_gap();
        send_bits(last_bits, 40);
        reset_now("reset mid-frame");

        idle_gap();
        run_full_frame("frame after reset", last_bits, last_fold, last_kind, 1'b0);

        if (checks_done > 0)
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
        else
        begin
            stop_with_error("no result was compared");
        end
    end

endmodule

// File: design/frame_checker_top.sv
`timescale 1ns/1ps

module frame_checker_top
    import checksum_pkg::*;
(
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  logic          en_i,
    input  logic          data_i,
    output logic          result_req_o,
    input  logic          result_ack_i,
    output frame_result_e result_kind_o,
    output logic [7:0]    result_sum_o
);

    logic       rx_active;
    logic       clear;
    logic       byte_done;
    logic       frame_done;
    logic       is_check_byte;
    logic [7:0] byte_q;

    // ==============================
    // control
    // ==============================

    frame_ctrl_fsm u_frame_ctrl_fsm (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .en_i         (en_i),
        .frame_done_i (frame_done),
        .result_ack_i (result_ack_i),
        .rx_active_o  (rx_active),
        .clear_o      (clear),
        .result_req_o (result_req_o)
    );

    bit_byte_counter u_bit_byte_counter (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .clear_i         (clear),
        .rx_active_i     (rx_active),
        .en_i            (en_i),
        .byte_done_o     (byte_done),
        .frame_done_o    (frame_done),
        .is_check_byte_o (is_check_byte)
    );

    // ==============================
    // datapath
    // ==============================

    serial_deserializer u_serial_deserializer (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .rx_active_i (rx_active),
        .en_i        (en_i),
        .data_i      (data_i),
        .byte_o      (byte_q)
    );

    checksum_accumulator u_checksum_accumulator (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .clear_i         (clear),
        .byte_done_i     (byte_done),
        .is_check_byte_i (is_check_byte),
        .byte_i          (byte_q),
        .kind_o          (result_kind_o),
        .sum_o           (result_sum_o)
    );

endmodule

// File: design/checksum_accumulator.sv
`timescale 1ns/1ps

module checksum_accumulator
    import checksum_pkg::*;
(
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  logic          clear_i,
    input  logic          byte_done_i,
    input  logic          is_check_byte_i,
    input  logic [7:0]    byte_i,
    output frame_result_e kind_o,
    output logic [7:0]    sum_o
);

    logic             byte_done_q;
    logic             check_q;
    logic [SUM_W-1:0] total_q;
    logic [7:0]       fold;
    logic [7:0]       check_sum;

    // carry out of the fold is dropped.
    assign fold      = total_q[SUM_W-1:8] + total_q[7:0];
    assign check_sum = fold + byte_i;

    // ==============================
    // byte strobe delay
    // ==============================

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            byte_done_q <= 1'b0;
            check_q     <= 1'b0;
        end
        else
        begin
            byte_done_q <= byte_done_i;
            check_q     <= byte_done_i & is_check_byte_i;
        end
    end

    // ==============================
    // sum and verdict
    // ==============================

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            total_q <= '0;
            sum_o   <= 8'd0;
            kind_o  <= RES_GOOD;
        end
        else if (clear_i)
        begin
            total_q <= '0;
        end
        else if (byte_done_q)
        begin
            if (check_q)
            begin
                sum_o  <= fold;
                kind_o <= (check_sum == CHECK_TARGET) ? RES_GOOD : RES_BAD;
            end
            else
            begin
                total_q <= total_q + {{(SUM_W-8){1'b0}}, byte_i};
            end
        end
    end

endmodule

// File: design/serial_deserializer.sv
`timescale 1ns/1ps

module serial_deserializer
    import checksum_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       rx_active_i,
    input  logic       en_i,
    input  logic       data_i,
    output logic [7:0] byte_o
);

    logic [BITS_PER_BYTE-1:0] byte_q;

    // lsb first, so new bits enter at the top.
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            byte_q <= '0;
        end
        else if (rx_active_i && en_i)
        begin
            byte_q <= {data_i, byte_q[BITS_PER_BYTE-1:1]};
        end
    end

    assign byte_o = byte_q;

endmodule

// File: design/bit_byte_counter.sv
`timescale 1ns/1ps

module bit_byte_counter
    import checksum_pkg::*;
(
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic clear_i,
    input  logic rx_active_i,
    input  logic en_i,
    output logic byte_done_o,
    output logic frame_done_o,
    output logic is_check_byte_o
);

    logic [2:0] bit_idx_q;
    logic [3:0] byte_idx_q;
    logic [2:0] bit_base;
    logic [3:0] byte_base;
    logic       advance;

    // clear and the first bit may share a cycle.
    assign bit_base  = clear_i ? 3'd0 : bit_idx_q;
    assign byte_base = clear_i ? 4'd0 : byte_idx_q;
    assign advance   = rx_active_i & en_i;

    assign byte_done_o     = advance && (bit_base == 3'(BITS_PER_BYTE - 1));
    assign is_check_byte_o = (byte_base == 4'(DATA_BYTES));
    assign frame_done_o    = byte_done_o && (byte_base == 4'(FRAME_BYTES - 1));

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            bit_idx_q  <= 3'd0;
            byte_idx_q <= 4'd0;
        end
        else if (advance)
        begin
            if (byte_done_o)
            begin
                bit_idx_q <= 3'd0;
                // wrap after the check byte.
                if (frame_done_o)
                begin
                    byte_idx_q <= 4'd0;
                end
                else
                begin
                    byte_idx_q <= byte_base + 4'd1;
                end
            end
            else
            begin
                bit_idx_q  <= bit_base + 3'd1;
                byte_idx_q <= byte_base;
            end
        end
        else
        begin
            bit_idx_q  <= bit_base;
            byte_idx_q <= byte_base;
        end
    end

endmodule

// File: design/frame_ctrl_fsm.sv
`timescale 1ns/1ps

module frame_ctrl_fsm
    import checksum_pkg::*;
(
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic en_i,
    input  logic frame_done_i,
    input  logic result_ack_i,
    output logic rx_active_o,
    output logic clear_o,
    output logic result_req_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // set for one cycle after the last frame bit.
    logic last_bit_q;

    // ==============================
    // state register
    // ==============================

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            state_q    <= ST_IDLE;
            last_bit_q <= 1'b0;
        end
        else
        begin
            state_q    <= state_d;
            last_bit_q <= frame_done_i;
        end
    end

    // ==============================
    // next state and strobes
    // ==============================

    always_comb
    begin
        state_d     = state_q;
        rx_active_o = 1'b0;
        clear_o     = 1'b0;
        case (state_q)
            ST_IDLE:
            begin
                // first bit is taken on the same edge.
                if (en_i)
                begin
                    clear_o     = 1'b1;
                    rx_active_o = 1'b1;
                    state_d     = ST_RECEIVE;
                end
            end
            ST_RECEIVE:
            begin
                if (last_bit_q)
                begin
                    state_d = ST_JUDGE;
                end
                else if (!en_i)
                begin
                    // abort drops the partial frame.
                    clear_o = 1'b1;
                    state_d = ST_IDLE;
                end
                else
                begin
                    rx_active_o = 1'b1;
                end
            end
            ST_JUDGE:
            begin
                state_d = ST_REPORT;
            end
            ST_REPORT:
            begin
                if (result_ack_i)
                begin
                    state_d = ST_RELEASE;
                end
            end
            ST_RELEASE:
            begin
                if (!result_ack_i)
                begin
                    state_d = ST_WAIT_LOW;
                end
            end
            ST_WAIT_LOW:
            begin
                // no new frame until the sender idles.
                if (!en_i)
                begin
                    state_d = ST_IDLE;
                end
            end
            default:
            begin
                state_d = ST_IDLE;
            end
        endcase
    end

    assign result_req_o = (state_q == ST_REPORT);

endmodule

// File: design/checksum_pkg.sv
package checksum_pkg;

    // ==============================
    // frame geometry
    // ==============================

    // serial bits per byte.
    localparam int BITS_PER_BYTE = 8;

    // bytes that enter the sum.
    localparam int DATA_BYTES = 8;

    // data bytes plus the check byte.
    localparam int FRAME_BYTES = 9;

    // ==============================
    // checksum arithmetic
    // ==============================

    // running sum width.
    localparam int SUM_W = 16;

    // fold plus check byte must land here.
    localparam logic [7:0] CHECK_TARGET = 8'hFF;

    // ==============================
    // types
    // ==============================

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_RECEIVE   = 3'd1,
        ST_JUDGE     = 3'd2,
        ST_REPORT    = 3'd3,
        ST_RELEASE   = 3'd4,
        ST_WAIT_LOW  = 3'd5
    } ctrl_state_e;

    typedef enum logic {
        RES_GOOD = 1'b0,
        RES_BAD  = 1'b1
    } frame_result_e;

endpackage
